// File: nes_mem_pkg.sv
`default_nettype none

package nes_mem_pkg;

	// **************************************************
	// Console address map and bus widths
	// **************************************************

	// CPU bus address width
	localparam int CPU_ADDR_W = 16;
	// PPU bus address width
	localparam int PPU_ADDR_W = 14;
	// Work RAM and name table, 2 KB each
	localparam int RAM_ADDR_W = 11;
	localparam int DATA_W = 8;

	// Character data sits above the 32 KB program area in SRAM
	localparam int unsigned CHR_SRAM_BASE = 'h8000;

	// Fixed name table mirroring, set per cartridge
	typedef enum logic
	{
		HORIZONTAL,
		VERTICAL
	} nt_mirror_e;

	// **************************************************
	// Bus bundles
	// **************************************************

	// CPU side, held from ph2 rising through ph2 falling
	typedef struct packed
	{
		logic [CPU_ADDR_W-1:0] addr;
		logic                  rnw;
		logic [DATA_W-1:0]     wdata;
	} cpu_bus_t;

	// PPU side, requests are single cycle pulses
	typedef struct packed
	{
		logic                  rd_req;
		logic                  wr_req;
		logic [PPU_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     wdata;
	} ppu_bus_t;

	// One cycle strobes from the CPU clock generator
	typedef struct packed
	{
		logic ph2_rising;
		logic ph2_falling;
	} cpu_phase_t;

endpackage

`default_nettype wire

// File: sram_pkg.sv
`default_nettype none

package sram_pkg;

	// **************************************************
	// External asynchronous SRAM, 128K x 16
	// **************************************************

	localparam int SRAM_WORD_ADDR_W = 17;
	localparam int SRAM_DATA_W = 16;
	// Byte address as seen by the bus ports, LSB picks the lane
	localparam int SRAM_BYTE_ADDR_W = SRAM_WORD_ADDR_W + 1;

	// Chip controls, all active low
	typedef struct packed
	{
		logic csn;
		logic oen;
		logic wen;
		logic lbn;
		logic hbn;
	} sram_ctrl_t;

	// One granted access from the arbiter
	typedef struct packed
	{
		logic                        rd;
		logic                        wr;
		// Set when the CPU issued the access
		logic                        cpu_owner;
		// Odd byte, upper lane
		logic                        upper;
		logic [SRAM_WORD_ADDR_W-1:0] word_addr;
		// Same byte on both lanes
		logic [SRAM_DATA_W-1:0]      wdata;
	} sram_req_t;

	// Pin driver state, follows the access on the pins
	typedef enum logic [1:0]
	{
		IDLE,
		READ,
		WRITE
	} sram_state_e;

endpackage

`default_nettype wire

// File: byte_ram.sv
`default_nettype none

module byte_ram #(
	parameter int READ_STAGES = 1
) (
	input  logic                             clk,
	input  logic                             en,
	input  logic                             we,
	input  logic [nes_mem_pkg::RAM_ADDR_W-1:0] addr,
	input  logic [nes_mem_pkg::DATA_W-1:0]     wdata,
	output logic [nes_mem_pkg::DATA_W-1:0]     rdata
);
	import nes_mem_pkg::*;

	// Block RAM array
	logic [DATA_W-1:0] mem [2**RAM_ADDR_W];
	// Output register chain, stage 0 is the array read
	logic [DATA_W-1:0] rd_stage [READ_STAGES];

	always_ff @(posedge clk)
	begin
		// Nothing moves while the region is not selected
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rd_stage[0] <= mem[addr];
			// Extra stages for the deeper pipelined port
			for (int i = 1; i < READ_STAGES; i++)
				rd_stage[i] <= rd_stage[i-1];
		end
	end

	// Last stage drives the port
	assign rdata = rd_stage[READ_STAGES-1];

endmodule

`default_nettype wire

// File: cpu_bus_port.sv
`default_nettype none

module cpu_bus_port (
	input  logic                                   clk,
	input  logic                                   rst,
	input  nes_mem_pkg::cpu_phase_t                phase,
	input  nes_mem_pkg::cpu_bus_t                  cpu,
	input  logic [nes_mem_pkg::DATA_W-1:0]         sram_rdata,
	input  logic                                   cpu_rd_done,
	output logic                                   cpu_sram_rd,
	output logic                                   cpu_sram_wr,
	output logic [sram_pkg::SRAM_BYTE_ADDR_W-1:0]  cpu_sram_byte_addr,
	output logic [nes_mem_pkg::DATA_W-1:0]         cpu_data_out
);
	import nes_mem_pkg::*;
	import sram_pkg::*;

	logic              wram_sel;
	logic              prg_sel;
	logic              wram_we;
	logic              wram_rd_ack;
	logic [DATA_W-1:0] wram_rdata;

	// **************************************************
	// Region decode
	// **************************************************

	// 0x0000-0x1FFF, 2 KB mirrored four times
	assign wram_sel = (cpu.addr[15:13] == 3'b000);
	// 0x8000-0xFFFF, program bytes in SRAM
	assign prg_sel = cpu.addr[15];

	// Program area starts at SRAM byte 0
	assign cpu_sram_byte_addr = SRAM_BYTE_ADDR_W'(cpu.addr[14:0]);

	// Read goes out at the start of the cycle, write at the end
	assign cpu_sram_rd = phase.ph2_rising & cpu.rnw & prg_sel;
	assign cpu_sram_wr = phase.ph2_falling & ~cpu.rnw & prg_sel;

	// **************************************************
	// Work RAM
	// **************************************************

	// Write data is valid by ph2 falling
	assign wram_we = phase.ph2_falling & ~cpu.rnw;

	byte_ram #(
		.READ_STAGES(1)
	) wram_i (
		.clk  (clk),
		.en   (wram_sel),
		.we   (wram_we),
		.addr (cpu.addr[RAM_ADDR_W-1:0]),
		.wdata(cpu.wdata),
		.rdata(wram_rdata)
	);

	// Work RAM data is out one cycle after ph2 rising
	always_ff @(posedge clk)
	begin
		if (rst)
			wram_rd_ack <= 1'b0;
		else
			wram_rd_ack <= phase.ph2_rising & cpu.rnw & wram_sel;
	end

	// **************************************************
	// CPU read data
	// **************************************************

	// Cleared at the end of every bus cycle
	always_ff @(posedge clk)
	begin
		if (rst || phase.ph2_falling)
			cpu_data_out <= '0;
		else if (wram_rd_ack)
			cpu_data_out <= wram_rdata;
		// SRAM byte arrives with the done pulse
		else if (cpu_rd_done)
			cpu_data_out <= sram_rdata;
	end

endmodule

`default_nettype wire

// File: ppu_bus_port.sv
`default_nettype none

module ppu_bus_port #(
	parameter nes_mem_pkg::nt_mirror_e NT_MIRRORING = nes_mem_pkg::VERTICAL
) (
	input  logic                                   clk,
	input  nes_mem_pkg::ppu_bus_t                  ppu,
	input  logic [nes_mem_pkg::DATA_W-1:0]         sram_rdata,
	output logic                                   ppu_sram_rd,
	output logic [sram_pkg::SRAM_BYTE_ADDR_W-1:0]  ppu_sram_byte_addr,
	output logic [nes_mem_pkg::DATA_W-1:0]         ppu_dout
);
	import nes_mem_pkg::*;
	import sram_pkg::*;

	logic                  nt_sel;
	logic                  nt_page;
	logic [RAM_ADDR_W-1:0] nt_addr;
	logic                  nt_we;
	logic [DATA_W-1:0]     nt_rdata;

	// **************************************************
	// Region decode
	// **************************************************

	// 0x2000-0x3FFF name and attribute tables
	assign nt_sel = ppu.addr[13];

	// Pattern tables live in SRAM, only reads go out
	assign ppu_sram_rd = ppu.rd_req & ~nt_sel;
	assign ppu_sram_byte_addr = SRAM_BYTE_ADDR_W'(CHR_SRAM_BASE)
		+ SRAM_BYTE_ADDR_W'(ppu.addr[12:0]);

	// **************************************************
	// Name table
	// **************************************************

	// Horizontal keeps bit 11, vertical keeps bit 10
	assign nt_page = (NT_MIRRORING == HORIZONTAL) ? ppu.addr[11] : ppu.addr[10];

	// Two 1 KB pages inside the 2 KB RAM
	assign nt_addr = {nt_page, ppu.addr[9:0]};

	assign nt_we = ppu.wr_req;

	// Address is held, so the pipe fills while the region is selected
	byte_ram #(
		.READ_STAGES(2)
	) nt_ram_i (
		.clk  (clk),
		.en   (nt_sel),
		.we   (nt_we),
		.addr (nt_addr),
		.wdata(ppu.wdata),
		.rdata(nt_rdata)
	);

	// **************************************************
	// Read data select
	// **************************************************

	// Picked by the region the address points to
	assign ppu_dout = nt_sel ? nt_rdata : sram_rdata;

endmodule

`default_nettype wire

// File: sram_arbiter.sv
`default_nettype none

module sram_arbiter (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   cpu_sram_rd,
	input  logic                                   cpu_sram_wr,
	input  logic [sram_pkg::SRAM_BYTE_ADDR_W-1:0]  cpu_sram_byte_addr,
	input  logic [nes_mem_pkg::DATA_W-1:0]         cpu_wdata,
	input  logic                                   ppu_sram_rd,
	input  logic [sram_pkg::SRAM_BYTE_ADDR_W-1:0]  ppu_sram_byte_addr,
	output sram_pkg::sram_req_t                    req
);
	import sram_pkg::*;

	logic                        cpu_rd_pend;
	logic                        cpu_rd_any;
	logic                        grant_wr;
	logic                        grant_ppu;
	logic                        grant_cpu_rd;
	logic [SRAM_BYTE_ADDR_W-1:0] grant_addr;

	logic                        rd_q;
	logic                        wr_q;
	logic                        owner_q;
	logic                        upper_q;
	logic [SRAM_WORD_ADDR_W-1:0] word_addr_q;
	logic [SRAM_DATA_W-1:0]      wdata_q;

	// **************************************************
	// Priority
	// **************************************************

	// New CPU read or the one left over from last cycle
	assign cpu_rd_any = cpu_sram_rd | cpu_rd_pend;

	// CPU write first, then PPU read, then CPU read
	assign grant_wr = cpu_sram_wr;
	assign grant_ppu = ~grant_wr & ppu_sram_rd;
	assign grant_cpu_rd = ~grant_wr & ~ppu_sram_rd & cpu_rd_any;

	// CPU address is held for the whole bus cycle, so a deferred read reuses it
	assign grant_addr = grant_ppu ? ppu_sram_byte_addr : cpu_sram_byte_addr;

	// Losing CPU read waits here
	always_ff @(posedge clk)
	begin
		if (rst)
			cpu_rd_pend <= 1'b0;
		else
			cpu_rd_pend <= cpu_rd_any & ~grant_cpu_rd;
	end

	// **************************************************
	// Request register
	// **************************************************

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
			owner_q <= 1'b0;
		end
		else
		begin
			rd_q <= grant_ppu | grant_cpu_rd;
			wr_q <= grant_wr;
			owner_q <= grant_wr | grant_cpu_rd;
		end
	end

	always_ff @(posedge clk)
	begin
		// Odd byte goes to the upper lane
		upper_q <= grant_addr[0];
		word_addr_q <= grant_addr[SRAM_BYTE_ADDR_W-1:1];
		// Mask picks the lane, the byte goes to both
		wdata_q <= {cpu_wdata, cpu_wdata};
	end

	always_comb
	begin
		req = '{
			rd: rd_q,
			wr: wr_q,
			cpu_owner: owner_q,
			upper: upper_q,
			word_addr: word_addr_q,
			wdata: wdata_q
		};
	end

endmodule

`default_nettype wire

// File: sram_phy.sv
`default_nettype none

module sram_phy (
	input  logic                                   clk,
	input  logic                                   rst,
	input  sram_pkg::sram_req_t                    req,
	input  logic [sram_pkg::SRAM_DATA_W-1:0]       sram_data_in,
	output sram_pkg::sram_ctrl_t                   sram_ctrl,
	output logic [sram_pkg::SRAM_WORD_ADDR_W-1:0]  sram_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0]       sram_data_out,
	output logic [sram_pkg::SRAM_DATA_W-1:0]       sram_data_t,
	output logic [nes_mem_pkg::DATA_W-1:0]         sram_rdata,
	output logic                                   cpu_rd_done
);
	import nes_mem_pkg::*;
	import sram_pkg::*;

	sram_state_e                 state_d;
	sram_state_e                 state_q;
	sram_ctrl_t                  ctrl_q;
	logic [SRAM_WORD_ADDR_W-1:0] addr_q;
	logic [SRAM_DATA_W-1:0]      dout_q;
	logic [SRAM_DATA_W-1:0]      data_t_q;
	// Lane and owner of the access now on the pins
	logic                        upper_q;
	logic                        owner_q;
	logic [SRAM_DATA_W-1:0]      din_q;
	logic                        lane_q;

	// **************************************************
	// Pin state
	// **************************************************

	// Write wins if both ever show up
	always_comb
	begin
		if (req.wr)
			state_d = WRITE;
		else if (req.rd)
			state_d = READ;
		else
			state_d = IDLE;
	end

	// One active cycle per request, back to idle unless another follows
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= IDLE;
			ctrl_q <= '1;
			data_t_q <= '1;
		end
		else
		begin
			state_q <= state_d;
			case (state_d)
				WRITE:
				begin
					ctrl_q <= '{csn: 1'b0, oen: 1'b1, wen: 1'b0,
						lbn: req.upper, hbn: ~req.upper};
					// Drive the data bus
					data_t_q <= '0;
				end
				READ:
				begin
					ctrl_q <= '{csn: 1'b0, oen: 1'b0, wen: 1'b1,
						lbn: req.upper, hbn: ~req.upper};
					data_t_q <= '1;
				end
				default:
				begin
					ctrl_q <= '1;
					data_t_q <= '1;
				end
			endcase
		end
	end

	// Address and write data follow the request
	always_ff @(posedge clk)
	begin
		if (req.rd || req.wr)
			addr_q <= req.word_addr;
		if (req.wr)
			dout_q <= req.wdata;
		if (req.rd)
		begin
			upper_q <= req.upper;
			owner_q <= req.cpu_owner;
		end
	end

	assign sram_ctrl = ctrl_q;
	assign sram_addr = addr_q;
	assign sram_data_out = dout_q;
	assign sram_data_t = data_t_q;

	// **************************************************
	// Read capture
	// **************************************************

	// Sample the bus at the end of the read cycle
	always_ff @(posedge clk)
	begin
		if (state_q == READ)
		begin
			din_q <= sram_data_in;
			lane_q <= upper_q;
		end
	end

	// Done pulse lines up with the captured byte
	always_ff @(posedge clk)
	begin
		if (rst)
			cpu_rd_done <= 1'b0;
		else
			cpu_rd_done <= (state_q == READ) & owner_q;
	end

	// Held until the next read
	assign sram_rdata = lane_q ? din_q[SRAM_DATA_W-1 -: DATA_W] : din_q[DATA_W-1:0];

endmodule

`default_nettype wire

// File: nes_mem_top.sv
`default_nettype none

module nes_mem_top #(
	parameter nes_mem_pkg::nt_mirror_e NT_MIRRORING = nes_mem_pkg::VERTICAL
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  nes_mem_pkg::cpu_phase_t                phase,
	input  nes_mem_pkg::cpu_bus_t                  cpu,
	input  nes_mem_pkg::ppu_bus_t                  ppu,
	input  logic [sram_pkg::SRAM_DATA_W-1:0]       sram_data_in,
	output logic [nes_mem_pkg::DATA_W-1:0]         cpu_data_out,
	output logic [nes_mem_pkg::DATA_W-1:0]         ppu_dout,
	output sram_pkg::sram_ctrl_t                   sram_ctrl,
	output logic [sram_pkg::SRAM_WORD_ADDR_W-1:0]  sram_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0]       sram_data_out,
	output logic [sram_pkg::SRAM_DATA_W-1:0]       sram_data_t
);
	import nes_mem_pkg::*;
	import sram_pkg::*;

	// Bus ports to arbiter
	logic                        cpu_sram_rd;
	logic                        cpu_sram_wr;
	logic [SRAM_BYTE_ADDR_W-1:0] cpu_sram_byte_addr;
	logic                        ppu_sram_rd;
	logic [SRAM_BYTE_ADDR_W-1:0] ppu_sram_byte_addr;
	// Arbiter to pin driver
	sram_req_t                   req;
	// Read data back to both ports
	logic [DATA_W-1:0]           sram_rdata;
	logic                        cpu_rd_done;

	cpu_bus_port cpu_bus_port_i (
		.clk               (clk),
		.rst               (rst),
		.phase             (phase),
		.cpu               (cpu),
		.sram_rdata        (sram_rdata),
		.cpu_rd_done       (cpu_rd_done),
		.cpu_sram_rd       (cpu_sram_rd),
		.cpu_sram_wr       (cpu_sram_wr),
		.cpu_sram_byte_addr(cpu_sram_byte_addr),
		.cpu_data_out      (cpu_data_out)
	);

	ppu_bus_port #(
		.NT_MIRRORING(NT_MIRRORING)
	) ppu_bus_port_i (
		.clk               (clk),
		.ppu               (ppu),
		.sram_rdata        (sram_rdata),
		.ppu_sram_rd       (ppu_sram_rd),
		.ppu_sram_byte_addr(ppu_sram_byte_addr),
		.ppu_dout          (ppu_dout)
	);

	// Single shared SRAM port
	sram_arbiter sram_arbiter_i (
		.clk               (clk),
		.rst               (rst),
		.cpu_sram_rd       (cpu_sram_rd),
		.cpu_sram_wr       (cpu_sram_wr),
		.cpu_sram_byte_addr(cpu_sram_byte_addr),
		.cpu_wdata         (cpu.wdata),
		.ppu_sram_rd       (ppu_sram_rd),
		.ppu_sram_byte_addr(ppu_sram_byte_addr),
		.req               (req)
	);

	sram_phy sram_phy_i (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.sram_data_in (sram_data_in),
		.sram_ctrl    (sram_ctrl),
		.sram_addr    (sram_addr),
		.sram_data_out(sram_data_out),
		.sram_data_t  (sram_data_t),
		.sram_rdata   (sram_rdata),
		.cpu_rd_done  (cpu_rd_done)
	);

endmodule

`default_nettype wire

// File: nes_mem_assertions.sv
`default_nettype none

module nes_mem_assertions (
	input logic                             clk,
	input logic                             rst,
	input sram_pkg::sram_ctrl_t             sram_ctrl,
	input logic [sram_pkg::SRAM_DATA_W-1:0] sram_data_t
);
	import sram_pkg::*;

	// **************************************************
	// SRAM pin protocol
	// **************************************************

	// Output enable and write enable are never active together
	property oe_we_exclusive;
		@(posedge clk) disable iff (rst)
		!(!sram_ctrl.oen && !sram_ctrl.wen);
	endproperty

	// Deselected chip sees no strobes
	property idle_strobes_high;
		@(posedge clk) disable iff (rst)
		sram_ctrl.csn |-> (sram_ctrl.oen && sram_ctrl.wen);
	endproperty

	// Data bus is driven only during a write
	property drive_only_on_write;
		@(posedge clk) disable iff (rst)
		(sram_data_t == '0) |-> !sram_ctrl.wen;
	endproperty

	assert property (oe_we_exclusive)
		else $error("SRAM oen and wen are low in the same cycle");
	assert property (idle_strobes_high)
		else $error("SRAM strobe active while csn is high");
	assert property (drive_only_on_write)
		else $error("SRAM data bus driven while wen is high");

endmodule

// Attach to every SRAM pin driver
bind sram_phy nes_mem_assertions nes_mem_assertions_i (
	.clk        (clk),
	.rst        (rst),
	.sram_ctrl  (sram_ctrl),
	.sram_data_t(sram_data_t)
);

`default_nettype wire

// File: nes_mem_tb.sv
`default_nettype none

module nes_mem_tb;
	import nes_mem_pkg::*;
	import sram_pkg::*;

	// Request sampled on the first edge, data due within 4 cycles after it
	localparam int READ_LIMIT = 5;

	logic                        clk;
	logic                        rst;
	cpu_phase_t                  phase;
	cpu_bus_t                    cpu;
	ppu_bus_t                    ppu;
	logic [SRAM_DATA_W-1:0]      sram_data_in;
	logic [DATA_W-1:0]           cpu_data_out;
	logic [DATA_W-1:0]           ppu_dout;
	sram_ctrl_t                  sram_ctrl;
	logic [SRAM_WORD_ADDR_W-1:0] sram_addr;
	logic [SRAM_DATA_W-1:0]      sram_data_out;
	logic [SRAM_DATA_W-1:0]      sram_data_t;

	integer seed = 32'hc9bf_a68f;
	int     checks = 0;
	int     errors = 0;
	int     checks_at_start;
	int     errors_at_start;

	// Behavioral SRAM and reference memories
	logic [SRAM_DATA_W-1:0] sram_mem [2**SRAM_WORD_ADDR_W];
	logic [DATA_W-1:0]      sram_ref [65536];
	logic [DATA_W-1:0]      wram_ref [2048];
	// All four logical tables, 0x2000-0x2FFF
	logic [DATA_W-1:0]      nt_ref [4096];
	// Addresses already written, reads pick from these
	logic [15:0]            wram_addrs[$];
	logic [15:0]            prg_addrs[$];
	logic [13:0]            nt_addrs[$];

	nes_mem_top #(
		.NT_MIRRORING(VERTICAL)
	) nes_mem_top_i (
		.clk          (clk),
		.rst          (rst),
		.phase        (phase),
		.cpu          (cpu),
		.ppu          (ppu),
		.sram_data_in (sram_data_in),
		.cpu_data_out (cpu_data_out),
		.ppu_dout     (ppu_dout),
		.sram_ctrl    (sram_ctrl),
		.sram_addr    (sram_addr),
		.sram_data_out(sram_data_out),
		.sram_data_t  (sram_data_t)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// **************************************************
	// SRAM model
	// **************************************************

	// Asynchronous read, both lanes driven
	assign sram_data_in = (!sram_ctrl.csn && !sram_ctrl.oen) ? sram_mem[sram_addr] : '0;

	// Write lanes mid cycle, pins are stable then
	always @(negedge clk)
	begin
		if (!sram_ctrl.csn && !sram_ctrl.wen)
		begin
			if (!sram_ctrl.lbn)
				sram_mem[sram_addr][7:0] <= sram_data_out[7:0];
			if (!sram_ctrl.hbn)
				sram_mem[sram_addr][15:8] <= sram_data_out[15:8];
		end
	end

	// Preload byte, every address bit takes part
	function automatic logic [7:0] fill_byte(input logic [17:0] b);
		return b[7:0] ^ {b[14:8], b[15]} ^ {6'b0, b[17:16]} ^ 8'h5a;
	endfunction

	// **************************************************
	// Check and report helpers
	// **************************************************

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic start_test();
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic finish_test(input string name);
		$display("%-20s %0d checks, %0d errors", name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	// Give the write time to reach the pins, then compare the whole word
	task automatic check_sram_word(input logic [16:0] word, input logic [15:0] exp);
		for (int k = 0; k < 4 && sram_mem[word] !== exp; k++)
		begin
			@(posedge clk);
			#2;
		end
		check_value("sram word", sram_mem[word], exp);
	endtask

	// **************************************************
	// Bus access tasks
	// **************************************************

	// One CPU bus cycle, optionally with a PPU pattern read on ph2 rising
	task automatic cpu_cycle(input logic [15:0] addr, input logic rnw,
		input logic [7:0] wdata, input logic [7:0] exp, input logic with_ppu,
		input logic [13:0] ppu_addr, input logic [7:0] ppu_exp);
		bit cpu_seen;
		bit ppu_seen;
		cpu_seen = 1'b0;
		ppu_seen = 1'b0;
		cpu.addr = addr;
		cpu.rnw = rnw;
		cpu.wdata = wdata;
		phase.ph2_rising = 1'b1;
		if (with_ppu)
		begin
			ppu.addr = ppu_addr;
			ppu.rd_req = 1'b1;
		end
		for (int k = 1; k <= 6; k++)
		begin
			@(posedge clk);
			#2;
			phase.ph2_rising = 1'b0;
			ppu.rd_req = 1'b0;
			if (k <= READ_LIMIT && rnw && cpu_data_out === exp)
				cpu_seen = 1'b1;
			// PPU byte stays only until the deferred CPU read lands
			if (k <= READ_LIMIT && with_ppu && ppu_dout === ppu_exp)
				ppu_seen = 1'b1;
		end
		if (rnw && !cpu_seen)
		begin
			errors++;
			$display("CPU read at %h returned no data within 4 cycles", addr);
		end
		if (with_ppu && !ppu_seen)
		begin
			errors++;
			$display("PPU read at %h returned no data within 4 cycles", ppu_addr);
		end
		// Last cycle before the bus cycle ends
		if (rnw)
			check_value("cpu_data_out", cpu_data_out, exp);
		phase.ph2_falling = 1'b1;
		@(posedge clk);
		#2;
		phase.ph2_falling = 1'b0;
		cpu.rnw = 1'b1;
	endtask

	// Address and data held for four cycles
	task automatic ppu_write(input logic [13:0] addr, input logic [7:0] data);
		ppu.addr = addr;
		ppu.wdata = data;
		ppu.wr_req = 1'b1;
		for (int k = 0; k < 4; k++)
		begin
			@(posedge clk);
			#2;
			ppu.wr_req = 1'b0;
		end
	endtask

	task automatic ppu_read(input logic [13:0] addr, input logic [7:0] exp);
		ppu.addr = addr;
		ppu.rd_req = 1'b1;
		for (int k = 0; k < 4; k++)
		begin
			@(posedge clk);
			#2;
			ppu.rd_req = 1'b0;
		end
		check_value("ppu_dout", ppu_dout, exp);
	endtask

	// **************************************************
	// Test sequence
	// **************************************************

	initial
	begin
		logic [31:0] r;
		logic [15:0] a;
		logic [13:0] pa;
		logic [7:0]  d;
		int          idx;

		rst = 1'b1;
		phase = '0;
		cpu = '{addr: '0, rnw: 1'b1, wdata: '0};
		ppu = '0;
		for (int w = 0; w < 2**SRAM_WORD_ADDR_W; w++)
			sram_mem[w] = {fill_byte(18'(2 * w + 1)), fill_byte(18'(2 * w))};
		for (int b = 0; b < 65536; b++)
			sram_ref[b] = fill_byte(18'(b));

		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// Pins idle, bus released, read data cleared
		start_test();
		check_value("sram_ctrl", sram_ctrl, 5'h1f);
		check_value("sram_data_t", sram_data_t, 16'hffff);
		check_value("cpu_data_out", cpu_data_out, 8'h00);
		finish_test("reset state");

		// Work RAM, reads go through a random mirror
		start_test();
		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			a = {3'b000, r[12:0]};
			d = r[23:16];
			cpu_cycle(a, 1'b0, d, 8'h00, 1'b0, 14'h0, 8'h00);
			wram_ref[a % 2048] = d;
			wram_addrs.push_back(a);
		end
		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			idx = r[15:0] % wram_addrs.size();
			a = {3'b000, r[17:16], wram_addrs[idx][10:0]};
			cpu_cycle(a, 1'b1, 8'h00, wram_ref[a % 2048], 1'b0, 14'h0, 8'h00);
		end
		finish_test("CPU work RAM");

		// Program SRAM, one lane per write
		start_test();
		for (int i = 0; i < 12; i++)
		begin
			r = $random(seed);
			a = {1'b1, r[14:0]};
			d = r[23:16];
			cpu_cycle(a, 1'b0, d, 8'h00, 1'b0, 14'h0, 8'h00);
			sram_ref[{1'b0, a[14:0]}] = d;
			prg_addrs.push_back(a);
			check_sram_word({3'b000, a[14:1]},
				{sram_ref[{1'b0, a[14:1], 1'b1}], sram_ref[{1'b0, a[14:1], 1'b0}]});
		end
		for (int i = 0; i < 12; i++)
		begin
			r = $random(seed);
			idx = r[15:0] % prg_addrs.size();
			a = prg_addrs[idx];
			cpu_cycle(a, 1'b1, 8'h00, sram_ref[{1'b0, a[14:0]}], 1'b0, 14'h0, 8'h00);
		end
		finish_test("CPU program SRAM");

		// Name table, reads may flip bit 11
		start_test();
		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			pa = {1'b1, r[12:0]};
			d = r[23:16];
			ppu_write(pa, d);
			// Vertical pairs differ only in bit 11, both see the byte
			nt_ref[pa[11:0]] = d;
			nt_ref[pa[11:0] ^ 12'h800] = d;
			nt_addrs.push_back(pa);
		end
		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			idx = r[15:0] % nt_addrs.size();
			pa = nt_addrs[idx] ^ {2'b00, r[20], 11'b0};
			ppu_read(pa, nt_ref[pa[11:0]]);
		end
		finish_test("PPU name table");

		// Pattern data from the preloaded SRAM area
		start_test();
		for (int i = 0; i < 12; i++)
		begin
			r = $random(seed);
			pa = {1'b0, r[12:0]};
			ppu_read(pa, sram_ref[CHR_SRAM_BASE + pa]);
		end
		finish_test("PPU character reads");

		// PPU wins the port, CPU read follows one cycle later
		start_test();
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			idx = r[15:0] % prg_addrs.size();
			a = prg_addrs[idx];
			pa = {1'b0, r[28:16]};
			cpu_cycle(a, 1'b1, 8'h00, sram_ref[{1'b0, a[14:0]}], 1'b1, pa,
				sram_ref[CHR_SRAM_BASE + pa]);
		end
		finish_test("SRAM conflict");

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: nes_mem.f
nes_mem_pkg.sv
sram_pkg.sv
byte_ram.sv
cpu_bus_port.sv
ppu_bus_port.sv
sram_arbiter.sv
sram_phy.sv
nes_mem_top.sv
nes_mem_assertions.sv
nes_mem_tb.sv
